// ==== tb.f ====
+incdir+include
logic/ntp_frame_pkg.sv
logic/keymem_pkg.sv
logic/rx_ip_aligner.sv
logic/ntp_field_capture.sv
logic/key_fetch.sv
logic/ntp_auth_top.sv
verification/ntp_auth_assertions.sv
verification/tb_ntp_auth.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the NTP auth testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_ntp_auth -f tb.f -o Vtb_ntp_auth

sim_out=$(./obj_dir/Vtb_ntp_auth 2>&1 || true)
echo "$sim_out"
if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1

// ==== verification/tb_ntp_auth.sv ====
/* NTP auth receive testbench
   Random IPv4, IPv6 and foreign frames, key fetch with a modelled key memory */

`timescale 1ns/1ps
`include "ntp_auth_macros.svh"

module tb_ntp_auth
  import ntp_frame_pkg::*;
  import keymem_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int FRAME_WORDS     = 18;
  localparam int FRAME_BYTES     = FRAME_WORDS * 8;
  localparam int V4_OFFSET       = `NTP_IPV4_START_WORD * 8 + 2;
  localparam int V6_OFFSET       = `NTP_IPV6_START_WORD * 8 + 6;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic           i_clk;
  logic           i_areset;
  logic           i_rx_reset;
  rx_beat_t       i_rx;
  logic           i_auth_start;
  keymem_rsp_t    i_keymem;
  ntp_rx_record_t o_rx_record;
  logic           o_ready;
  logic           o_key_ok;
  auth_key_t      o_key;
  keymem_req_t    o_keymem;

  logic [7:0]     frame_bytes [0:FRAME_BYTES-1];
  ntp_rx_record_t exp_record;
  keyid_t         exp_keyid;
  auth_key_t      exp_key;
  logic           exp_key_ok;
  key_word_t      key_words [0:`NTP_KEY_WORDS-1];
  int             mem_order [0:`NTP_KEY_WORDS-1];
  int             mem_words;
  int             mem_sent;
  logic           mem_busy;
  logic           compare_req;
  logic           compare_key;
  string          compare_test;
  int             error_count;
  int             seed_ret;

  ntp_auth_top UUT (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_rx_reset   (i_rx_reset),
    .i_rx         (i_rx),
    .i_auth_start (i_auth_start),
    .i_keymem     (i_keymem),
    .o_rx_record  (o_rx_record),
    .o_ready      (o_ready),
    .o_key_ok     (o_key_ok),
    .o_key        (o_key),
    .o_keymem     (o_keymem)
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // --------------------
  // Reference model and checks
  // --------------------
  // Payload bytes from offset: 48 header, 4 key id, 20 digest
  function automatic ntp_rx_record_t expected_record(input ip_ver_e ver, input int offset);
    ntp_rx_record_t rec;
    rec = '0;
    rec.ip_ver = ver;
    if (ver != IP_NONE) begin
      for (int i = 0; i < 48; i++)
        rec.header[383-8*i -: 8] = frame_bytes[offset+i];
      for (int i = 0; i < 4; i++)
        rec.keyid[31-8*i -: 8] = frame_bytes[offset+48+i];
      for (int i = 0; i < 20; i++)
        rec.digest[159-8*i -: 8] = frame_bytes[offset+52+i];
      rec.complete = 1'b1;
    end
    return rec;
  endfunction

  function automatic rx_word_t frame_word(input int w);
    rx_word_t word;
    for (int b = 0; b < 8; b++)
      word[63-8*b -: 8] = frame_bytes[8*w+b];
    return word;
  endfunction

  task automatic check_value(input string test_name, input string field,
                             input logic [383:0] expected, input logic [383:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("error: test %s %s expected %h actual %h", test_name, field, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Compares outputs one cycle after a request from the stimulus
  always @(posedge i_clk) begin
    if (compare_req) begin
      if (!compare_key) begin
        check_value(compare_test, "complete", exp_record.complete, o_rx_record.complete);
        check_value(compare_test, "ip_ver", exp_record.ip_ver, o_rx_record.ip_ver);
        check_value(compare_test, "header", exp_record.header, o_rx_record.header);
        check_value(compare_test, "keyid", exp_record.keyid, o_rx_record.keyid);
        check_value(compare_test, "digest", exp_record.digest, o_rx_record.digest);
      end else begin
        check_value(compare_test, "key_ok", exp_key_ok, o_key_ok);
        if (exp_key_ok)
          check_value(compare_test, "key", exp_key, o_key);
      end
      compare_req <= 1'b0;
    end
  end

  task automatic request_compare(input string test_name, input logic key_mode);
    compare_test = test_name;
    compare_key  = key_mode;
    compare_req <= 1'b1;
    @(posedge i_clk);
    while (compare_req)
      @(posedge i_clk);
  endtask

  // --------------------
  // Key memory model
  // --------------------
  initial begin
    i_keymem = '0;
    i_keymem.ready = 1'b1;
    mem_busy = 1'b0;
    mem_sent = 0;
    forever begin
      @(posedge i_clk);
      if (mem_busy) begin
        if (mem_sent < mem_words) begin
          i_keymem.key_valid <= 1'b1;
          i_keymem.key_word  <= key_index_t'(mem_order[mem_sent]);
          i_keymem.key_data  <= key_words[mem_order[mem_sent]];
          mem_sent <= mem_sent + 1;
        end else begin
          i_keymem.key_valid <= 1'b0;
          i_keymem.ready     <= 1'b1;
          mem_busy <= 1'b0;
        end
      end else if (o_keymem.get) begin
        check_value(compare_test, "request keyid", exp_keyid, o_keymem.keyid);
        i_keymem.ready     <= 1'b0;
        i_keymem.key_valid <= 1'b0;
        mem_sent <= 0;
        mem_busy <= 1'b1;
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic run_frame(input string test_name, input logic [15:0] etype,
                           input ip_ver_e ver, input int offset);
    for (int i = 0; i < FRAME_BYTES; i++)
      frame_bytes[i] = 8'($urandom);
    frame_bytes[12] = etype[15:8];
    frame_bytes[13] = etype[7:0];
    @(posedge i_clk);
    i_rx_reset <= 1'b1;
    @(posedge i_clk);
    i_rx_reset <= 1'b0;
    for (int w = 0; w < FRAME_WORDS; w++) begin
      i_rx.valid <= 1'b1;
      i_rx.data  <= frame_word(w);
      @(posedge i_clk);
    end
    i_rx.valid <= 1'b0;
    i_rx.data  <= '0;
    repeat (12) @(posedge i_clk);
    exp_record = expected_record(ver, offset);
    request_compare(test_name, 1'b0);
  endtask

  task automatic run_key_fetch(input string test_name, input int words);
    int j;
    int tmp;
    for (int i = 0; i < `NTP_KEY_WORDS; i++) begin
      key_words[i] = $urandom;
      mem_order[i] = i;
    end
    for (int i = `NTP_KEY_WORDS - 1; i > 0; i--) begin
      j = $urandom_range(i, 0);
      tmp = mem_order[i];
      mem_order[i] = mem_order[j];
      mem_order[j] = tmp;
    end
    // Never hand the words back in index order
    if (mem_order[0] == 0) begin
      mem_order[0] = mem_order[4];
      mem_order[4] = 0;
    end
    for (int i = 0; i < `NTP_KEY_WORDS; i++)
      exp_key[i*32 +: 32] = key_words[i];
    exp_key_ok   = (words == `NTP_KEY_WORDS);
    exp_keyid    = exp_record.keyid;
    mem_words    = words;
    compare_test = test_name;
    @(posedge i_clk);
    i_auth_start <= 1'b1;
    @(posedge i_clk);
    i_auth_start <= 1'b0;
    do
      @(posedge i_clk);
    while (!o_ready);
    request_compare(test_name, 1'b1);
  endtask

  initial begin
    seed_ret     = $urandom(32'hafebf9d6);
    error_count  = 0;
    compare_req  = 1'b0;
    compare_key  = 1'b0;
    compare_test = "reset";
    exp_record   = '0;
    i_areset     = 1'b1;
    i_rx_reset   = 1'b0;
    i_rx         = '0;
    i_auth_start = 1'b0;
    repeat (3) @(posedge i_clk);
    i_areset <= 1'b0;

    run_frame("ipv4_frame", `NTP_ETYPE_IPV4, IP_V4, V4_OFFSET);
    run_key_fetch("key_fetch_ok", `NTP_KEY_WORDS);
    run_frame("ipv6_frame", `NTP_ETYPE_IPV6, IP_V6, V6_OFFSET);
    run_frame("other_ethertype", 16'h0806, IP_NONE, 0);
    run_key_fetch("key_short_reply", 3);

    repeat (2) @(posedge i_clk);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== verification/ntp_auth_assertions.sv ====
/* Key fetch protocol assertions
   Request pulse, request key id and start/ready behavior */

`timescale 1ns/1ps

module ntp_auth_assertions
  import keymem_pkg::*;
(
  input logic        i_clk,
  input logic        i_areset,
  input logic        i_auth_start,
  input logic        i_ready,
  input keymem_rsp_t i_keymem,
  input keymem_req_t i_keymem_req
);

  // Request is a single-cycle pulse
  get_one_cycle: assert property (@(posedge i_clk) disable iff (i_areset)
    i_keymem_req.get |=> !i_keymem_req.get)
    else $error("key memory get held longer than one cycle");

  // Key id must be defined when the request goes out
  get_keyid_known: assert property (@(posedge i_clk) disable iff (i_areset)
    i_keymem_req.get |-> !$isunknown(i_keymem_req.keyid))
    else $error("key memory get issued with an undefined key id");

  get_while_busy: assert property (@(posedge i_clk) disable iff (i_areset)
    i_keymem_req.get |-> !i_ready)
    else $error("key memory get issued while ready is high");

  // Ready only drops after an accepted start
  ready_drop_after_start: assert property (@(posedge i_clk) disable iff (i_areset)
    $fell(i_ready) |-> $past(i_auth_start))
    else $error("ready dropped without a start request");

endmodule

bind key_fetch ntp_auth_assertions u_assertions (
  .i_clk        (i_clk),
  .i_areset     (i_areset),
  .i_auth_start (i_auth_start),
  .i_ready      (o_ready),
  .i_keymem     (i_keymem),
  .i_keymem_req (o_keymem)
);

// ==== logic/ntp_auth_top.sv ====
/* NTP authentication receive top
   Frame alignment, NTP field capture and key fetch */

`timescale 1ns/1ps

module ntp_auth_top
  import ntp_frame_pkg::*;
  import keymem_pkg::*;
(
  input  logic           i_clk,
  input  logic           i_areset,
  input  logic           i_rx_reset,
  input  rx_beat_t       i_rx,
  input  logic           i_auth_start,
  input  keymem_rsp_t    i_keymem,
  output ntp_rx_record_t o_rx_record,
  output logic           o_ready,
  output logic           o_key_ok,
  output auth_key_t      o_key,
  output keymem_req_t    o_keymem
);

  ip_ver_e       ip_ver;
  aligned_word_t aligned;

  rx_ip_aligner u_aligner (
    .i_clk      (i_clk),
    .i_areset   (i_areset),
    .i_rx_reset (i_rx_reset),
    .i_rx       (i_rx),
    .o_ip_ver   (ip_ver),
    .o_aligned  (aligned)
  );

  ntp_field_capture u_capture (
    .i_clk      (i_clk),
    .i_areset   (i_areset),
    .i_rx_reset (i_rx_reset),
    .i_ip_ver   (ip_ver),
    .i_aligned  (aligned),
    .o_record   (o_rx_record)
  );

  // Key id comes straight from the captured record
  key_fetch u_key_fetch (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_auth_start (i_auth_start),
    .i_keyid      (o_rx_record.keyid),
    .i_keymem     (i_keymem),
    .o_ready      (o_ready),
    .o_key_ok     (o_key_ok),
    .o_key        (o_key),
    .o_keymem     (o_keymem)
  );

endmodule

// ==== logic/key_fetch.sv ====
/* Key fetch
   Start/ready control around a key memory request, collects the five
   indexed key words and flags whether the key arrived in full */

`timescale 1ns/1ps
`include "ntp_auth_macros.svh"

module key_fetch
  import ntp_frame_pkg::*;
  import keymem_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_areset,
  input  logic        i_auth_start,
  input  keyid_t      i_keyid,
  input  keymem_rsp_t i_keymem,
  output logic        o_ready,
  output logic        o_key_ok,
  output auth_key_t   o_key,
  output keymem_req_t o_keymem
);

  localparam int KEY_W = $bits(key_word_t);
  localparam logic [`NTP_KEY_WORDS-1:0] ALL_SEEN = '1;

  key_fsm_e                  state;
  logic                      ready_reg;
  logic                      key_ok_reg;
  keyid_t                    keyid_reg;
  auth_key_t                 key_reg;
  logic [`NTP_KEY_WORDS-1:0] seen;
  logic [`NTP_KEY_WORDS-1:0] seen_next;
  logic                      start_ok;
  logic                      get;
  logic                      word_in;

  assign start_ok = i_auth_start && ready_reg;
  // Request goes out in the cycle the memory reports ready
  assign get      = (state == KEY_REQUEST) && i_keymem.ready;
  assign word_in  = (state == KEY_COLLECT) && i_keymem.key_valid &&
                    (i_keymem.key_word < `NTP_KEY_WORDS);

  // Words may come in any order
  always_comb begin
    seen_next = seen;
    if (word_in)
      seen_next[i_keymem.key_word] = 1'b1;
  end

  // --------------------
  // Fetch FSM
  // --------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state      <= KEY_IDLE;
      ready_reg  <= 1'b1;
      key_ok_reg <= 1'b0;
      seen       <= '0;
    end else begin
      case (state)
        KEY_IDLE:
          if (start_ok) begin
            ready_reg <= 1'b0;
            state     <= KEY_REQUEST;
          end
        KEY_REQUEST:
          if (get) begin
            key_ok_reg <= 1'b0;
            seen       <= '0;
            state      <= KEY_COLLECT;
          end
        KEY_COLLECT: begin
          seen <= seen_next;
          if (seen_next == ALL_SEEN)
            state <= KEY_SUCCESS;
          else if (i_keymem.ready && !i_keymem.key_valid)
            state <= KEY_ERROR; // memory finished early
        end
        KEY_SUCCESS: begin
          key_ok_reg <= 1'b1;
          ready_reg  <= 1'b1;
          state      <= KEY_IDLE;
        end
        KEY_ERROR: begin
          key_ok_reg <= 1'b0;
          ready_reg  <= 1'b1;
          state      <= KEY_IDLE;
        end
        default: begin
          ready_reg <= 1'b1;
          state     <= KEY_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (start_ok)
      keyid_reg <= i_keyid;
    if (word_in)
      key_reg[i_keymem.key_word*KEY_W +: KEY_W] <= i_keymem.key_data;
  end

  assign o_ready        = ready_reg;
  assign o_key_ok       = key_ok_reg;
  assign o_key          = key_reg;
  assign o_keymem.get   = get;
  assign o_keymem.keyid = keyid_reg;

endmodule

// ==== logic/ntp_field_capture.sv ====
/* NTP field capture
   Sorts aligned payload words into the NTP header, key id and digest */

`timescale 1ns/1ps
`include "ntp_auth_macros.svh"

module ntp_field_capture
  import ntp_frame_pkg::*;
(
  input  logic           i_clk,
  input  logic           i_areset,
  input  logic           i_rx_reset,
  input  ip_ver_e        i_ip_ver,
  input  aligned_word_t  i_aligned,
  output ntp_rx_record_t o_record
);

  localparam int RX_W = $bits(rx_word_t);
  localparam word_cnt_t KEYID_WORD   = word_cnt_t'(`NTP_HDR_WORDS);
  localparam word_cnt_t DIG_MID_WORD = KEYID_WORD + word_cnt_t'(1);
  localparam word_cnt_t DIG_LOW_WORD = KEYID_WORD + word_cnt_t'(2);

  word_cnt_t   ntp_cnt;
  logic [2:0]  hdr_slot;
  ntp_header_t header;
  keyid_t      keyid;
  ntp_digest_t digest;
  logic        complete;

  // Word 0 lands in the top slot
  assign hdr_slot = 3'(`NTP_HDR_WORDS - 1) - ntp_cnt[2:0];

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      ntp_cnt  <= '0;
      header   <= '0;
      keyid    <= '0;
      digest   <= '0;
      complete <= 1'b0;
    end else if (i_rx_reset) begin
      ntp_cnt  <= '0;
      header   <= '0;
      keyid    <= '0;
      digest   <= '0;
      complete <= 1'b0;
    end else if (i_aligned.valid) begin
      if (ntp_cnt != `NTP_CNT_MAX)
        ntp_cnt <= ntp_cnt + 1'b1;
      if (ntp_cnt < KEYID_WORD) begin
        header[hdr_slot*RX_W +: RX_W] <= i_aligned.data;
      end else if (ntp_cnt == KEYID_WORD) begin
        keyid          <= i_aligned.data[63:32];
        digest[159:128] <= i_aligned.data[31:0];
      end else if (ntp_cnt == DIG_MID_WORD) begin
        digest[127:64] <= i_aligned.data;
      end else if (ntp_cnt == DIG_LOW_WORD) begin
        digest[63:0] <= i_aligned.data;
        complete     <= 1'b1;
      end
      // Anything after the digest is dropped
    end
  end

  always_comb begin
    o_record.ip_ver   = i_ip_ver;
    o_record.header   = header;
    o_record.keyid    = keyid;
    o_record.digest   = digest;
    o_record.complete = complete;
  end

endmodule

// ==== logic/rx_ip_aligner.sv ====
/* RX IP aligner
   Counts frame words, detects IPv4 or IPv6 from the EtherType and shifts
   the NTP payload onto 64-bit word boundaries */

`timescale 1ns/1ps
`include "ntp_auth_macros.svh"

module rx_ip_aligner
  import ntp_frame_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_areset,
  input  logic          i_rx_reset,
  input  rx_beat_t      i_rx,
  output ip_ver_e       o_ip_ver,
  output aligned_word_t o_aligned
);

  localparam int RX_W = $bits(rx_word_t);
  // Payload bytes left in the start word, in bits
  localparam int V4_TAIL = 48;
  localparam int V6_TAIL = 16;
  localparam word_cnt_t V4_START = word_cnt_t'(`NTP_IPV4_START_WORD);
  localparam word_cnt_t V6_START = word_cnt_t'(`NTP_IPV6_START_WORD);

  word_cnt_t rx_cnt;
  ip_ver_e   ip_ver;

  logic                     v4_take;
  logic                     v4_prev_valid;
  logic [V4_TAIL-1:0]       v4_prev_tail;
  logic [RX_W-V4_TAIL-1:0]  v4_head;
  logic                     v4_cur_valid;
  rx_word_t                 v4_cur;

  logic                     v6_take;
  logic                     v6_prev_valid;
  logic [V6_TAIL-1:0]       v6_prev_tail;
  logic [RX_W-V6_TAIL-1:0]  v6_head;
  logic                     v6_cur_valid;
  rx_word_t                 v6_cur;

  assign v4_take = i_rx.valid && (ip_ver == IP_V4) && (rx_cnt >= V4_START);
  assign v6_take = i_rx.valid && (ip_ver == IP_V6) && (rx_cnt >= V6_START);

  // Head of the following beat, zero once the frame has ended
  assign v4_head = i_rx.valid ? i_rx.data[RX_W-1 -: RX_W-V4_TAIL] : '0;
  assign v6_head = i_rx.valid ? i_rx.data[RX_W-1 -: RX_W-V6_TAIL] : '0;

  // --------------------
  // Word counter and EtherType
  // --------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      rx_cnt <= '0;
      ip_ver <= IP_NONE;
    end else if (i_rx_reset) begin
      rx_cnt <= '0;
      ip_ver <= IP_NONE;
    end else if (i_rx.valid) begin
      if (rx_cnt != `NTP_CNT_MAX)
        rx_cnt <= rx_cnt + 1'b1;
      if (rx_cnt == word_cnt_t'(1)) begin
        case (i_rx.data[31:16])
          `NTP_ETYPE_IPV4: ip_ver <= IP_V4;
          `NTP_ETYPE_IPV6: ip_ver <= IP_V6;
          default:         ip_ver <= IP_NONE;
        endcase
      end
    end
  end

  // --------------------
  // Previous and current stages
  // --------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      v4_prev_valid <= 1'b0;
      v4_cur_valid  <= 1'b0;
      v6_prev_valid <= 1'b0;
      v6_cur_valid  <= 1'b0;
    end else if (i_rx_reset) begin
      v4_prev_valid <= 1'b0;
      v4_cur_valid  <= 1'b0;
      v6_prev_valid <= 1'b0;
      v6_cur_valid  <= 1'b0;
    end else begin
      v4_prev_valid <= v4_take;
      v4_cur_valid  <= v4_prev_valid;
      v6_prev_valid <= v6_take;
      v6_cur_valid  <= v6_prev_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (v4_take)
      v4_prev_tail <= i_rx.data[V4_TAIL-1:0];
    if (v4_prev_valid)
      v4_cur <= {v4_prev_tail, v4_head};
    if (v6_take)
      v6_prev_tail <= i_rx.data[V6_TAIL-1:0];
    if (v6_prev_valid)
      v6_cur <= {v6_prev_tail, v6_head};
  end

  // Only the stage of the detected version drives the output
  always_comb begin
    o_aligned = '0;
    case (ip_ver)
      IP_V4: begin
        o_aligned.valid = v4_cur_valid;
        o_aligned.data  = v4_cur;
      end
      IP_V6: begin
        o_aligned.valid = v6_cur_valid;
        o_aligned.data  = v6_cur;
      end
      default: ;
    endcase
  end

  assign o_ip_ver = ip_ver;

endmodule

// ==== logic/keymem_pkg.sv ====
/* Key memory types
   Request and reply of the key memory, key storage and fetch states */

package keymem_pkg;

  import ntp_frame_pkg::*;

  typedef logic [31:0]  key_word_t;
  typedef logic [2:0]   key_index_t;

  // Word n of the key at bits n*32 upward
  typedef logic [159:0] auth_key_t;

  typedef struct packed {
    logic   get;
    keyid_t keyid;
  } keymem_req_t;

  typedef struct packed {
    logic       ready;
    logic       key_valid;
    key_index_t key_word;
    key_word_t  key_data;
  } keymem_rsp_t;

  typedef enum logic [2:0] {
    KEY_IDLE,
    KEY_REQUEST,
    KEY_COLLECT,
    KEY_SUCCESS,
    KEY_ERROR
  } key_fsm_e;

endpackage

// ==== logic/ntp_frame_pkg.sv ====
/* NTP receive frame types
   Frame words, aligned payload words and the captured NTP record */

package ntp_frame_pkg;

  typedef logic [63:0]  rx_word_t;
  typedef logic [15:0]  word_cnt_t;
  typedef logic [31:0]  keyid_t;
  typedef logic [159:0] ntp_digest_t;

  // First received header word sits in the top bits
  typedef logic [383:0] ntp_header_t;

  typedef enum logic [1:0] {
    IP_NONE,
    IP_V4,
    IP_V6
  } ip_ver_e;

  // One beat of the incoming frame
  typedef struct packed {
    logic     valid;
    rx_word_t data;
  } rx_beat_t;

  // Payload word after re-alignment
  typedef struct packed {
    logic     valid;
    rx_word_t data;
  } aligned_word_t;

  typedef struct packed {
    ip_ver_e     ip_ver;
    ntp_header_t header;
    keyid_t      keyid;
    ntp_digest_t digest;
    logic        complete;
  } ntp_rx_record_t;

endpackage

// ==== include/ntp_auth_macros.svh ====
/* NTP authentication constants
   EtherType codes, payload positions, field sizes and counter limits */

`ifndef NTP_AUTH_MACROS_SVH
`define NTP_AUTH_MACROS_SVH

// --------------------
// EtherType values
// --------------------
`define NTP_ETYPE_IPV4 16'h0800
`define NTP_ETYPE_IPV6 16'h86DD

// Frame word where the NTP payload begins
`define NTP_IPV4_START_WORD 5
`define NTP_IPV6_START_WORD 7

// --------------------
// Field sizes
// --------------------
`define NTP_HDR_WORDS 6
`define NTP_KEY_WORDS 5

`define NTP_CNT_MAX 16'hFFFF

`endif
